// ==== array_pkg.sv ====
package array_pkg;

  // array geometry and run lengths
  localparam int array_dim = 4;
  localparam int num_classes = 3;
  localparam int feat_len = 64;
  localparam int drain_len = 3;
  localparam int shifter_depth = 16;
  localparam int word_steps = 8;

  // tensor memory layout
  localparam logic [31:0] w_base = 32'd0;
  localparam logic [31:0] b_base = 32'd64;

  // counter and fill level widths
  localparam int cnt_w = $clog2(feat_len + 1);
  localparam int level_w = $clog2(shifter_depth) + 1;

  typedef logic [7:0] byte_t;
  typedef byte_t [array_dim-1:0] lane_vec_t;
  typedef logic signed [31:0] acc_t;

  // a tensor memory word holds either four weight bytes or one bias
  typedef union packed {
    lane_vec_t weight;
    acc_t      bias;
  } tensor_word_u;

  // img[k] is the one-hot class of image k, class 0 in the top bit
  typedef struct packed {
    logic                                  valid;
    logic [18:0]                           pad;
    logic [array_dim-1:0][num_classes-1:0] img;
  } shape_t;

endpackage

// ==== class_store.sv ====
`timescale 1ns/1ns

module class_store (
  input  logic                    clk,
  input  logic                    rst,
  input  array_pkg::acc_t [array_pkg::array_dim-1:0][array_pkg::array_dim-1:0] array_out,
  input  array_pkg::tensor_word_u rdata,
  input  ctrl_pkg::seq_cmd_t      cmd,
  output array_pkg::shape_t       shape
);
  import array_pkg::*;

  // score[k][c] is image k against class c
  acc_t [array_dim-1:0][num_classes-1:0] score;

  // signed argmax, strict compare keeps the lower class on a tie
  function automatic logic [num_classes-1:0] pick_class(acc_t [num_classes-1:0] s);
    int best;
    best = 0;
    for (int c = 1; c < num_classes; c++) begin
      if ($signed(s[c]) > $signed(s[best])) begin
        best = c;
      end
    end
    pick_class = '0;
    pick_class[num_classes - 1 - best] = 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (cmd.clear_all) begin
      score <= '0;
    end else if (cmd.capture) begin
      // column k is image k and row c is class c
      for (int k = 0; k < array_dim; k++) begin
        for (int c = 0; c < num_classes; c++) begin
          score[k][c] <= array_out[k][c];
        end
      end
    end else if (cmd.bias_en) begin
      for (int k = 0; k < array_dim; k++) begin
        score[k][cmd.bias_idx] <= score[k][cmd.bias_idx] + rdata.bias;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shape <= '0;
    end else if (cmd.clear_all) begin
      shape <= '0;
    end else if (cmd.classify) begin
      shape.valid <= 1'b1;
      for (int k = 0; k < array_dim; k++) begin
        shape.img[k] <= pick_class(score[k]);
      end
    end
  end

endmodule

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

  // cpu register offsets
  localparam logic [31:0] addr_start = 32'h4;
  localparam logic [31:0] addr_pixel = 32'h8;

  // run states of the sequencer
  typedef enum logic [3:0] {
    idle,
    fill,
    stream,
    stall,
    drain,
    store,
    bias,
    classify,
    done
  } run_state_t;

  // one cpu request, lw high for a read
  typedef struct packed {
    logic        req;
    logic        lw;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mmio_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } mmio_rsp_t;

  // per-cycle command from the sequencer to the data path
  typedef struct packed {
    logic       clear_all;
    logic       shift_step;
    logic       load_rows;
    logic       capture;
    logic       bias_en;
    logic [1:0] bias_idx;
    logic       classify;
  } seq_cmd_t;

endpackage

// ==== mmio_regs.sv ====
`timescale 1ns/1ns

module mmio_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  ctrl_pkg::mmio_req_t  mmio_in,
  input  logic                 credit_return,
  input  array_pkg::shape_t    shape,
  input  ctrl_pkg::run_state_t state,
  output ctrl_pkg::mmio_rsp_t  mmio_out,
  output logic                 start,
  output logic                 pixel_valid,
  output logic [31:0]          pixel_word
);
  import ctrl_pkg::*;
  import array_pkg::*;

  logic       wr;
  logic       rd;
  logic       take;
  logic       give;
  logic [1:0] credits;
  // credits handed out this run, capped at the word count
  logic [3:0] granted;

  assign wr = mmio_in.req && !mmio_in.lw;
  assign rd = mmio_in.req && mmio_in.lw;
  assign start = wr && (mmio_in.addr == addr_start) && (state == idle || state == done);
  assign pixel_valid = wr && (mmio_in.addr == addr_pixel);
  assign pixel_word = mmio_in.wdata;
  assign take = pixel_valid && (credits != '0);
  assign give = credit_return && (granted < 4'(feat_len / word_steps));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mmio_out <= '0;
    end else begin
      mmio_out.ack <= mmio_in.req;
      mmio_out.rdata <= '0;
      if (rd && mmio_in.addr == addr_start) begin
        mmio_out.rdata <= shape;
      end else if (rd && mmio_in.addr == addr_pixel) begin
        mmio_out.rdata <= 32'(credits);
      end
    end
  end

  // shifter starts empty so one credit per word of room
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credits <= '0;
      granted <= '0;
    end else if (start) begin
      credits <= 2'(shifter_depth / word_steps);
      granted <= 4'(shifter_depth / word_steps);
    end else begin
      credits <= credits + 2'(give) - 2'(take);
      granted <= granted + 4'(give);
    end
  end

  a_credit_cap: assert property (@(posedge clk) disable iff (rst)
    credits <= 2'(shifter_depth / word_steps));

endmodule

// ==== pixel_shifter.sv ====
`timescale 1ns/1ns

module pixel_shifter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pixel_valid,
  input  logic [31:0]          pixel_word,
  input  ctrl_pkg::seq_cmd_t   cmd,
  output array_pkg::lane_vec_t col_input,
  output logic                 has_data,
  output logic                 credit_return
);
  import array_pkg::*;

  // entry 0 is the next step to leave
  lane_vec_t [shifter_depth-1:0] fifo;
  lane_vec_t [shifter_depth-1:0] fifo_nxt;
  logic [level_w-1:0]            level;
  logic [level_w-1:0]            level_nxt;
  logic [$clog2(word_steps)-1:0] pop_cnt;
  logic                          pop;
  logic                          accept;

  assign pop = cmd.shift_step && cmd.load_rows;
  assign accept = pixel_valid && (level <= level_w'(shifter_depth - word_steps));
  assign has_data = (level != '0);

  always_comb begin
    fifo_nxt = fifo;
    level_nxt = level;
    if (pop) begin
      fifo_nxt = {lane_vec_t'(0), fifo[shifter_depth-1:1]};
      level_nxt = level - 1'b1;
    end
    // bit j of byte b is image b at step j
    if (accept) begin
      for (int j = 0; j < word_steps; j++) begin
        for (int b = 0; b < array_dim; b++) begin
          fifo_nxt[level_nxt + j][b] = {7'b0, pixel_word[$bits(byte_t) * b + j]};
        end
      end
      level_nxt = level_nxt + level_w'(word_steps);
    end
  end

  always_ff @(posedge clk) begin
    fifo <= fifo_nxt;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      level <= '0;
      pop_cnt <= '0;
      col_input <= '0;
      credit_return <= 1'b0;
    end else if (cmd.clear_all) begin
      level <= '0;
      pop_cnt <= '0;
      col_input <= '0;
      credit_return <= 1'b0;
    end else begin
      level <= level_nxt;
      credit_return <= pop && (pop_cnt == ($clog2(word_steps))'(word_steps - 1));
      if (pop) begin
        pop_cnt <= pop_cnt + 1'b1;
      end
      // drain cycles feed zero columns
      if (cmd.shift_step) begin
        col_input <= pop ? fifo[0] : lane_vec_t'(0);
      end
    end
  end

  a_word_fits: assert property (@(posedge clk) disable iff (rst)
    pixel_valid |-> level <= level_w'(shifter_depth - word_steps));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tensor_controller.f --top-module tb_tensor_controller -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -Fqx "RESULT: PASS"; then
  exit 0
fi
exit 1

// ==== step_counter.sv ====
`timescale 1ns/1ns

module step_counter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        inc,
  input  logic                        clr,
  output logic [array_pkg::cnt_w-1:0] count,
  output logic                        last_step,
  output logic                        drain_done
);
  import array_pkg::*;

  // shared by the step, drain and bias phases
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (clr) begin
      count <= '0;
    end else if (inc) begin
      count <= count + 1'b1;
    end
  end

  assign last_step = (count == cnt_w'(feat_len - 1));

  // one count past the last drain enable
  assign drain_done = (count == cnt_w'(drain_len));

endmodule

// ==== tb_tensor_controller.sv ====
`timescale 1ns/1ns

module tb_tensor_controller;
  import ctrl_pkg::*;
  import array_pkg::*;

  localparam int runs = 6;
  localparam int limit_cycles = runs * (feat_len * 4 + 100);
  localparam int init_credits = shifter_depth / word_steps;
  localparam int max_returns = feat_len / word_steps - init_credits;

  logic clk = 1'b0;
  logic rst = 1'b1;
  mmio_req_t mmio_in = '0;
  mmio_rsp_t mmio_out;
  logic ren;
  logic [31:0] raddr;
  tensor_word_u rdata = '0;
  logic clear;
  logic en;
  lane_vec_t col_input;
  lane_vec_t row_input;
  acc_t [array_dim-1:0][array_dim-1:0] acc = '0;

  // column history for the array model, hist[k][d] is column k d+1 enables back
  byte_t [array_dim-1:0][array_dim-2:0] hist = '0;
  tensor_word_u mem [0:127];
  logic [31:0] px_words [0:word_steps-1];
  int run_en = 0;
  int run_writes = 0;
  bit running = 1'b0;
  int credit_at_req;
  logic seen_clear;
  logic seen_ren;
  logic [31:0] seen_raddr;
  int checks = 0;
  int col_checks = 0;
  int err_cpu = 0;
  int err_col = 0;
  int seed_dummy;

  tensor_controller dut0 (
    .clk(clk), .rst(rst), .mmio_in(mmio_in), .mmio_out(mmio_out), .ren(ren),
    .raddr(raddr), .rdata(rdata), .clear(clear), .en(en), .col_input(col_input),
    .row_input(row_input), .array_out(acc)
  );

  always #10 clk = ~clk;

  function automatic acc_t sext(byte_t b);
    return {{24{b[7]}}, b};
  endfunction

  // tensor memory answers one cycle after ren
  always @(posedge clk) begin
    if (ren) begin
      rdata <= mem[raddr[6:0]];
    end
  end

  // array model, row i meets column data delayed by i enables
  always @(posedge clk) begin
    if (rst || clear) begin
      acc <= '0;
      hist <= '0;
    end else if (en) begin
      for (int k = 0; k < array_dim; k++) begin
        acc[k][0] <= acc[k][0] + sext(row_input[0]) * acc_t'({24'b0, col_input[k]});
        for (int i = 1; i < array_dim; i++) begin
          acc[k][i] <= acc[k][i] + sext(row_input[i]) * acc_t'({24'b0, hist[k][i-1]});
        end
        hist[k][0] <= col_input[k];
        for (int d = 1; d < array_dim - 1; d++) begin
          hist[k][d] <= hist[k][d-1];
        end
      end
    end
  end

  function automatic lane_vec_t expected_col(int step);
    lane_vec_t v;
    v = '0;
    if (step < feat_len) begin
      for (int b = 0; b < array_dim; b++) begin
        v[b] = {7'b0, px_words[step / word_steps][8 * b + step % word_steps]};
      end
    end
    return v;
  endfunction

  // every enable carries the next pixel step, drain enables carry zeros
  always @(posedge clk) begin
    if (clear) begin
      run_en <= 0;
    end else if (en) begin
      col_checks++;
      if (run_en >= feat_len + drain_len || col_input != expected_col(run_en)) begin
        $display("ERR %0t: column input %h at enable %0d, expected %h", $time, col_input,
                 run_en, expected_col(run_en));
        err_col++;
      end
      run_en <= run_en + 1;
    end
  end

  function automatic int credit_model();
    int back;
    back = run_en / word_steps;
    if (back > max_returns) begin
      back = max_returns;
    end
    return running ? init_credits + back - run_writes : 0;
  endfunction

  // signed argmax per image over score = sum of pixel times weight plus bias
  function automatic logic [31:0] expected_shape();
    acc_t sc [num_classes];
    int best;
    logic [31:0] res;
    res = 32'h8000_0000;
    for (int k = 0; k < array_dim; k++) begin
      for (int c = 0; c < num_classes; c++) begin
        sc[c] = mem[b_base + c].bias;
        for (int s = 0; s < feat_len; s++) begin
          if (px_words[s / word_steps][8 * k + s % word_steps]) begin
            sc[c] = sc[c] + sext(mem[s].weight[c]);
          end
        end
      end
      best = 0;
      for (int c = 1; c < num_classes; c++) begin
        if (sc[c] > sc[best]) begin
          best = c;
        end
      end
      res[3 * k + num_classes - 1 - best] = 1'b1;
    end
    return res;
  endfunction

  task automatic note_err(string msg);
    $display("ERR %0t: %s", $time, msg);
    err_cpu++;
  endtask

  // one request, checks the ack lands exactly one cycle later
  task automatic cpu_access(input logic lw, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rd);
    mmio_in <= '{req: 1'b1, lw: lw, addr: addr, wdata: wdata};
    @(posedge clk);
    mmio_in <= '0;
    credit_at_req = credit_model();
    checks++;
    if (mmio_out.ack !== 1'b0) begin
      note_err($sformatf("ack came in the request cycle for address %h", addr));
    end
    @(posedge clk);
    if (mmio_out.ack !== 1'b1) begin
      note_err($sformatf("no ack one cycle after request to address %h", addr));
    end
    rd = mmio_out.rdata;
    seen_clear = clear;
    seen_ren = ren;
    seen_raddr = raddr;
  endtask

  task automatic do_run(input bit tie);
    logic [31:0] rd;
    logic [31:0] w;
    logic [31:0] want;
    int sent;
    int gap;
    for (int s = 0; s < feat_len; s++) begin
      w = $urandom;
      if (tie) begin
        w[23:8] = {w[7:0], w[7:0]};
      end
      mem[s] = w;
    end
    for (int c = 0; c < num_classes; c++) begin
      mem[b_base + c].bias = tie ? 32'sd17 : acc_t'(int'($urandom % 1024) - 512);
    end
    for (int i = 0; i < word_steps; i++) begin
      px_words[i] = $urandom;
    end
    cpu_access(1'b0, addr_start, 32'h0, rd);
    running = 1'b1;
    run_writes = 0;
    checks++;
    if (!(seen_clear && seen_ren && seen_raddr == w_base)) begin
      note_err($sformatf("start gave clear %b ren %b raddr %h", seen_clear, seen_ren, seen_raddr));
    end
    cpu_access(1'b1, addr_start, 32'h0, rd);
    if (rd != 32'h0) begin
      note_err($sformatf("shape %h not cleared by start", rd));
    end
    sent = 0;
    while (sent < word_steps) begin
      gap = ($urandom % 4 == 0) ? 12 : int'($urandom % 3);
      repeat (gap) @(posedge clk);
      cpu_access(1'b1, addr_pixel, 32'h0, rd);
      if (credit_at_req < 0 || rd != 32'(credit_at_req)) begin
        note_err($sformatf("credits %0d, expected %0d", rd, credit_at_req));
      end
      if (rd != 32'h0) begin
        cpu_access(1'b0, addr_pixel, px_words[sent], rd);
        sent++;
        run_writes++;
      end
    end
    rd = '0;
    while (!rd[31]) begin
      cpu_access(1'b1, addr_start, 32'h0, rd);
    end
    want = expected_shape();
    checks++;
    if (tie && rd != {1'b1, 19'b0, {array_dim{3'b100}}}) begin
      note_err($sformatf("tie shape %h does not pick class 0", rd));
    end
    if (rd != want) begin
      note_err($sformatf("shape %h, expected %h", rd, want));
    end
    if (run_en != feat_len + drain_len) begin
      note_err($sformatf("%0d enables in run, expected %0d", run_en, feat_len + drain_len));
    end
  endtask

  initial begin
    logic [31:0] rd;
    seed_dummy = $urandom(66121);
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    checks++;
    if (en || clear || ren) begin
      note_err($sformatf("after reset en %b clear %b ren %b", en, clear, ren));
    end
    cpu_access(1'b1, addr_pixel, 32'h0, rd);
    if (rd != 32'h0) begin
      note_err($sformatf("credits %0d after reset", rd));
    end
    cpu_access(1'b1, addr_start, 32'h0, rd);
    if (rd != 32'h0) begin
      note_err($sformatf("shape %h after reset", rd));
    end
    for (int r = 0; r < runs; r++) begin
      do_run(r == runs - 2);
    end
    repeat (4) @(posedge clk);
    $display("checks %0d column checks %0d cpu errors %0d column errors %0d",
             checks, col_checks, err_cpu, err_col);
    if (err_cpu == 0 && err_col == 0 && col_checks > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: no final result after %0d cycles", limit_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== tensor_controller.f ====
ctrl_pkg.sv
array_pkg.sv
step_counter.sv
mmio_regs.sv
pixel_shifter.sv
weight_skewer.sv
class_store.sv
tensor_sequencer.sv
tensor_controller.sv
tb_tensor_controller.sv

// ==== tensor_controller.sv ====
`timescale 1ns/1ns

module tensor_controller (
  input  logic                    clk,
  input  logic                    rst,
  input  ctrl_pkg::mmio_req_t     mmio_in,
  output ctrl_pkg::mmio_rsp_t     mmio_out,
  output logic                    ren,
  output logic [31:0]             raddr,
  input  array_pkg::tensor_word_u rdata,
  output logic                    clear,
  output logic                    en,
  output array_pkg::lane_vec_t    col_input,
  output array_pkg::lane_vec_t    row_input,
  input  array_pkg::acc_t [array_pkg::array_dim-1:0][array_pkg::array_dim-1:0] array_out
);
  import ctrl_pkg::*;
  import array_pkg::*;

  seq_cmd_t         cmd;
  run_state_t       state;
  shape_t           shape;
  logic             start;
  logic             pixel_valid;
  logic [31:0]      pixel_word;
  logic             credit_return;
  logic             has_data;
  logic             last_step;
  logic             drain_done;
  logic             cnt_inc;
  logic             cnt_clr;
  logic [cnt_w-1:0] count;

  mmio_regs u_regs (
    .clk(clk), .rst(rst), .mmio_in(mmio_in), .credit_return(credit_return),
    .shape(shape), .state(state), .mmio_out(mmio_out), .start(start),
    .pixel_valid(pixel_valid), .pixel_word(pixel_word)
  );

  tensor_sequencer u_seq (
    .clk(clk), .rst(rst), .start(start), .has_data(has_data),
    .last_step(last_step), .drain_done(drain_done), .count(count),
    .state(state), .cmd(cmd), .ren(ren), .raddr(raddr), .en(en),
    .clear(clear), .cnt_inc(cnt_inc), .cnt_clr(cnt_clr)
  );

  step_counter u_cnt (
    .clk(clk), .rst(rst), .inc(cnt_inc), .clr(cnt_clr),
    .count(count), .last_step(last_step), .drain_done(drain_done)
  );

  pixel_shifter u_pix (
    .clk(clk), .rst(rst), .pixel_valid(pixel_valid), .pixel_word(pixel_word),
    .cmd(cmd), .col_input(col_input), .has_data(has_data),
    .credit_return(credit_return)
  );

  weight_skewer u_skew (
    .clk(clk), .rst(rst), .rdata(rdata), .cmd(cmd), .row_input(row_input)
  );

  class_store u_class (
    .clk(clk), .rst(rst), .array_out(array_out), .rdata(rdata),
    .cmd(cmd), .shape(shape)
  );

endmodule

// ==== tensor_sequencer.sv ====
`timescale 1ns/1ns

module tensor_sequencer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic                          has_data,
  input  logic                          last_step,
  input  logic                          drain_done,
  input  logic [array_pkg::cnt_w-1:0]   count,
  output ctrl_pkg::run_state_t          state,
  output ctrl_pkg::seq_cmd_t            cmd,
  output logic                          ren,
  output logic [31:0]                   raddr,
  output logic                          en,
  output logic                          clear,
  output logic                          cnt_inc,
  output logic                          cnt_clr
);
  import ctrl_pkg::*;
  import array_pkg::*;

  run_state_t state_nxt;

  // rdata always belongs to the address issued in the previous cycle
  always_comb begin
    state_nxt = state;
    cmd = '0;
    ren = 1'b0;
    raddr = '0;
    cnt_inc = 1'b0;
    cnt_clr = 1'b0;
    case (state)
      idle, done: begin
        if (start) begin
          cmd.clear_all = 1'b1;
          cnt_clr = 1'b1;
          state_nxt = fill;
        end
      end
      fill: begin
        ren = 1'b1;
        raddr = w_base + 32'(count);
        state_nxt = stream;
      end
      stream: begin
        if (has_data) begin
          cmd.shift_step = 1'b1;
          cmd.load_rows = 1'b1;
          if (last_step) begin
            cnt_clr = 1'b1;
            state_nxt = drain;
          end else begin
            cnt_inc = 1'b1;
            ren = 1'b1;
            raddr = w_base + 32'(count) + 32'd1;
          end
        end else begin
          // weight in rdata is dropped and read again on resume
          state_nxt = stall;
        end
      end
      stall: begin
        if (has_data) begin
          ren = 1'b1;
          raddr = w_base + 32'(count);
          state_nxt = stream;
        end
      end
      drain: begin
        // the extra count lets the last enable land before capture
        if (drain_done) begin
          cnt_clr = 1'b1;
          state_nxt = store;
        end else begin
          cmd.shift_step = 1'b1;
          cnt_inc = 1'b1;
        end
      end
      store: begin
        cmd.capture = 1'b1;
        ren = 1'b1;
        raddr = b_base + 32'(count);
        state_nxt = bias;
      end
      bias: begin
        cmd.bias_en = 1'b1;
        cmd.bias_idx = count[1:0];
        if (count == cnt_w'(num_classes - 1)) begin
          cnt_clr = 1'b1;
          state_nxt = classify;
        end else begin
          cnt_inc = 1'b1;
          ren = 1'b1;
          raddr = b_base + 32'(count) + 32'd1;
        end
      end
      classify: begin
        cmd.classify = 1'b1;
        state_nxt = done;
      end
      default: state_nxt = idle;
    endcase
  end

  // en and clear line up with the registered column and row outputs
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= idle;
      en <= 1'b0;
      clear <= 1'b0;
    end else begin
      state <= state_nxt;
      en <= cmd.shift_step;
      clear <= cmd.clear_all;
    end
  end

  a_no_en_at_rest: assert property (@(posedge clk) disable iff (rst)
    (state == idle || state == done) |-> !en);

endmodule

// ==== weight_skewer.sv ====
`timescale 1ns/1ns

module weight_skewer (
  input  logic                    clk,
  input  logic                    rst,
  input  array_pkg::tensor_word_u rdata,
  input  ctrl_pkg::seq_cmd_t      cmd,
  output array_pkg::lane_vec_t    row_input
);
  import array_pkg::*;

  // line[i][d] holds lane i's byte d shifts after it entered
  lane_vec_t [array_dim-1:0] line;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      line <= '0;
    end else if (cmd.clear_all) begin
      line <= '0;
    end else if (cmd.shift_step) begin
      for (int i = 0; i < array_dim; i++) begin
        line[i] <= {line[i][array_dim-2:0], cmd.load_rows ? rdata.weight[i] : 8'h00};
      end
    end
  end

  // lane i is tapped i stages deep so it trails lane 0 by i enables
  always_comb begin
    for (int i = 0; i < array_dim; i++) begin
      row_input[i] = line[i][i];
    end
  end

endmodule
